// File: design/alu.sv
`default_nettype none

module alu (
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  backend_pkg::id_ex_t    in_payload_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output backend_pkg::ex_wb_t    out_payload_o,
    output logic                   fwd_en_o,
    output backend_pkg::reg_addr_t fwd_addr_o,
    output backend_pkg::word_t     fwd_data_o
);
    import backend_pkg::*;

    word_t result;

    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

    always_comb begin
        case (in_payload_i.alu_op)
            ALU_ADD: result = in_payload_i.src1 + in_payload_i.src2;
            ALU_SUB: result = in_payload_i.src1 - in_payload_i.src2;
            ALU_AND: result = in_payload_i.src1 & in_payload_i.src2;
            ALU_OR:  result = in_payload_i.src1 | in_payload_i.src2;
            ALU_XOR: result = in_payload_i.src1 ^ in_payload_i.src2;
            ALU_SLL: result = in_payload_i.src1 << in_payload_i.src2[4:0];
            ALU_SRL: result = in_payload_i.src1 >> in_payload_i.src2[4:0];
            // immediate already shifted up by the decoder
            ALU_LUI: result = in_payload_i.src2;
            default: result = '0;
        endcase
    end

    assign out_payload_o.pc             = in_payload_i.pc;
    assign out_payload_o.inst           = in_payload_i.inst;
    assign out_payload_o.reg_write_en   = in_payload_i.reg_write_en;
    assign out_payload_o.reg_write_addr = in_payload_i.reg_write_addr;
    assign out_payload_o.reg_write_data = result;
    assign out_payload_o.illegal        = in_payload_i.illegal;

    // execute bypass, held while the stage stalls
    assign fwd_en_o   = in_valid_i && in_payload_i.reg_write_en;
    assign fwd_addr_o = in_payload_i.reg_write_addr;
    assign fwd_data_o = result;

endmodule

`default_nettype wire

// File: design/backend.sv
`default_nettype none

module backend (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   inst_valid_i,
    input  backend_pkg::word_t     inst_i,
    input  backend_pkg::word_t     pc_i,
    output logic                   inst_ready_o,
    output logic                   commit_valid_o,
    input  logic                   commit_ready_i,
    output backend_pkg::word_t     debug_wb_pc_o,
    output backend_pkg::word_t     debug_wb_inst_o,
    output logic [3:0]             debug_wb_rf_wen_o,
    output backend_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output backend_pkg::word_t     debug_wb_rf_wdata_o,
    output logic [63:0]            retired_count_o
);
    import backend_pkg::*;

    // buffer head
    logic      head_valid;
    logic      head_ready;
    word_t     head_inst;
    word_t     head_pc;

    // register file
    reg_addr_t rf_addr_a;
    reg_addr_t rf_addr_b;
    word_t     rf_data_a;
    word_t     rf_data_b;
    logic      rf_write_en;
    reg_addr_t rf_write_addr;
    word_t     rf_write_data;

    // decode to execute
    logic      dec_valid;
    logic      dec_ready;
    id_ex_t    dec_payload;
    logic      ex_valid;
    logic      ex_ready;
    id_ex_t    ex_payload;

    // execute to commit
    logic      alu_valid;
    logic      alu_ready;
    ex_wb_t    alu_payload;
    logic      wb_valid;
    logic      wb_ready;
    ex_wb_t    wb_payload;

    // bypass
    logic      ex_fwd_en;
    reg_addr_t ex_fwd_addr;
    word_t     ex_fwd_data;
    logic      wb_fwd_en;
    reg_addr_t wb_fwd_addr;
    word_t     wb_fwd_data;

    inst_buffer u_inst_buffer (
        .clk,
        .reset_i,
        .inst_valid_i,
        .inst_i,
        .pc_i,
        .inst_ready_o,
        .head_valid_o (head_valid),
        .head_inst_o  (head_inst),
        .head_pc_o    (head_pc),
        .head_ready_i (head_ready)
    );

    regfile u_regfile (
        .clk,
        .reset_i,
        .read_addr_a_i (rf_addr_a),
        .read_addr_b_i (rf_addr_b),
        .read_data_a_o (rf_data_a),
        .read_data_b_o (rf_data_b),
        .write_en_i    (rf_write_en),
        .write_addr_i  (rf_write_addr),
        .write_data_i  (rf_write_data)
    );

    decoder u_decoder (
        .in_valid_i    (head_valid),
        .in_ready_o    (head_ready),
        .out_valid_o   (dec_valid),
        .out_ready_i   (dec_ready),
        .inst_i        (head_inst),
        .pc_i          (head_pc),
        .rf_addr_a_o   (rf_addr_a),
        .rf_addr_b_o   (rf_addr_b),
        .rf_data_a_i   (rf_data_a),
        .rf_data_b_i   (rf_data_b),
        .ex_fwd_en_i   (ex_fwd_en),
        .ex_fwd_addr_i (ex_fwd_addr),
        .ex_fwd_data_i (ex_fwd_data),
        .wb_fwd_en_i   (wb_fwd_en),
        .wb_fwd_addr_i (wb_fwd_addr),
        .wb_fwd_data_i (wb_fwd_data),
        .payload_o     (dec_payload)
    );

    pipe_stage #(
        .payload_t (id_ex_t)
    ) u_id_ex (
        .clk,
        .reset_i,
        .in_valid_i    (dec_valid),
        .in_ready_o    (dec_ready),
        .in_payload_i  (dec_payload),
        .out_valid_o   (ex_valid),
        .out_ready_i   (ex_ready),
        .out_payload_o (ex_payload)
    );

    alu u_alu (
        .in_valid_i    (ex_valid),
        .in_ready_o    (ex_ready),
        .in_payload_i  (ex_payload),
        .out_valid_o   (alu_valid),
        .out_ready_i   (alu_ready),
        .out_payload_o (alu_payload),
        .fwd_en_o      (ex_fwd_en),
        .fwd_addr_o    (ex_fwd_addr),
        .fwd_data_o    (ex_fwd_data)
    );

    pipe_stage #(
        .payload_t (ex_wb_t)
    ) u_ex_wb (
        .clk,
        .reset_i,
        .in_valid_i    (alu_valid),
        .in_ready_o    (alu_ready),
        .in_payload_i  (alu_payload),
        .out_valid_o   (wb_valid),
        .out_ready_i   (wb_ready),
        .out_payload_o (wb_payload)
    );

    commit_port u_commit_port (
        .clk,
        .reset_i,
        .in_valid_i      (wb_valid),
        .in_ready_o      (wb_ready),
        .in_payload_i    (wb_payload),
        .commit_valid_o,
        .commit_ready_i,
        .rf_write_en_o   (rf_write_en),
        .rf_write_addr_o (rf_write_addr),
        .rf_write_data_o (rf_write_data),
        .fwd_en_o        (wb_fwd_en),
        .fwd_addr_o      (wb_fwd_addr),
        .fwd_data_o      (wb_fwd_data),
        .debug_wb_pc_o,
        .debug_wb_inst_o,
        .debug_wb_rf_wen_o,
        .debug_wb_rf_wnum_o,
        .debug_wb_rf_wdata_o,
        .retired_count_o
    );

endmodule

`default_nettype wire

// File: design/backend_pkg.sv
`default_nettype none

package backend_pkg;

    localparam int NUM_REGS          = 32;
    localparam int INST_BUFFER_DEPTH = 2;
    localparam int INST_BUFFER_PTR_W = $clog2(INST_BUFFER_DEPTH);
    localparam int INST_BUFFER_CNT_W = $clog2(INST_BUFFER_DEPTH + 1);

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // 3R group, matched against inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;
    localparam logic [16:0] OP_SLL_W = 17'h0002e;
    localparam logic [16:0] OP_SRL_W = 17'h0002f;

    // inst[31:22] and inst[31:25]
    localparam logic [9:0] OP_ADDI_W  = 10'h00a;
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    // field positions
    localparam int RD_LSB   = 0;
    localparam int RJ_LSB   = 5;
    localparam int RK_LSB   = 10;
    localparam int SI12_LSB = 10;
    localparam int SI20_LSB = 5;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        logic      illegal;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        word_t     reg_write_data;
        logic      illegal;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: design/commit_port.sv
`default_nettype none

module commit_port (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  backend_pkg::ex_wb_t    in_payload_i,
    output logic                   commit_valid_o,
    input  logic                   commit_ready_i,
    output logic                   rf_write_en_o,
    output backend_pkg::reg_addr_t rf_write_addr_o,
    output backend_pkg::word_t     rf_write_data_o,
    output logic                   fwd_en_o,
    output backend_pkg::reg_addr_t fwd_addr_o,
    output backend_pkg::word_t     fwd_data_o,
    output backend_pkg::word_t     debug_wb_pc_o,
    output backend_pkg::word_t     debug_wb_inst_o,
    output logic [3:0]             debug_wb_rf_wen_o,
    output backend_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output backend_pkg::word_t     debug_wb_rf_wdata_o,
    output logic [63:0]            retired_count_o
);
    import backend_pkg::*;

    logic commit;
    logic writes_rd;

    assign commit_valid_o = in_valid_i;
    assign in_ready_o     = commit_ready_i;
    assign commit         = in_valid_i && commit_ready_i;

    // illegal words and r0 targets retire without a write
    assign writes_rd = in_payload_i.reg_write_en && !in_payload_i.illegal &&
                       (in_payload_i.reg_write_addr != '0);

    assign rf_write_en_o   = commit && writes_rd;
    assign rf_write_addr_o = in_payload_i.reg_write_addr;
    assign rf_write_data_o = in_payload_i.reg_write_data;

    assign fwd_en_o   = in_valid_i && writes_rd;
    assign fwd_addr_o = in_payload_i.reg_write_addr;
    assign fwd_data_o = in_payload_i.reg_write_data;

    assign debug_wb_pc_o       = in_payload_i.pc;
    assign debug_wb_inst_o     = in_payload_i.inst;
    assign debug_wb_rf_wen_o   = {4{in_valid_i && writes_rd}};
    assign debug_wb_rf_wnum_o  = in_payload_i.reg_write_addr;
    assign debug_wb_rf_wdata_o = in_payload_i.reg_write_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retired_count_o <= '0;
        end else if (commit) begin
            retired_count_o <= retired_count_o + 64'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/decoder.sv
`default_nettype none

module decoder (
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    input  backend_pkg::word_t     inst_i,
    input  backend_pkg::word_t     pc_i,
    output backend_pkg::reg_addr_t rf_addr_a_o,
    output backend_pkg::reg_addr_t rf_addr_b_o,
    input  backend_pkg::word_t     rf_data_a_i,
    input  backend_pkg::word_t     rf_data_b_i,
    input  logic                   ex_fwd_en_i,
    input  backend_pkg::reg_addr_t ex_fwd_addr_i,
    input  backend_pkg::word_t     ex_fwd_data_i,
    input  logic                   wb_fwd_en_i,
    input  backend_pkg::reg_addr_t wb_fwd_addr_i,
    input  backend_pkg::word_t     wb_fwd_data_i,
    output backend_pkg::id_ex_t    payload_o
);
    import backend_pkg::*;

    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    word_t     imm;
    word_t     src1;
    word_t     src2_reg;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      illegal;

    // no stall of its own, the head simply waits on the stage behind
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

    assign rd = inst_i[RD_LSB +: 5];
    assign rj = inst_i[RJ_LSB +: 5];
    assign rk = inst_i[RK_LSB +: 5];

    assign rf_addr_a_o = rj;
    assign rf_addr_b_o = rk;

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        illegal = 1'b0;
        imm     = {{20{inst_i[SI12_LSB + 11]}}, inst_i[SI12_LSB +: 12]};
        if (inst_i[31:15] == OP_ADD_W) begin
            alu_op = ALU_ADD;
        end else if (inst_i[31:15] == OP_SUB_W) begin
            alu_op = ALU_SUB;
        end else if (inst_i[31:15] == OP_AND) begin
            alu_op = ALU_AND;
        end else if (inst_i[31:15] == OP_OR) begin
            alu_op = ALU_OR;
        end else if (inst_i[31:15] == OP_XOR) begin
            alu_op = ALU_XOR;
        end else if (inst_i[31:15] == OP_SLL_W) begin
            alu_op = ALU_SLL;
        end else if (inst_i[31:15] == OP_SRL_W) begin
            alu_op = ALU_SRL;
        end else if (inst_i[31:22] == OP_ADDI_W) begin
            use_imm = 1'b1;
        end else if (inst_i[31:25] == OP_LU12I_W) begin
            alu_op  = ALU_LUI;
            use_imm = 1'b1;
            imm     = {inst_i[SI20_LSB +: 20], 12'h000};
        end else begin
            illegal = 1'b1;
        end
    end

    // youngest producer wins, r0 never shows up on a bypass
    assign src1 = (ex_fwd_en_i && (ex_fwd_addr_i == rj)) ? ex_fwd_data_i :
                  (wb_fwd_en_i && (wb_fwd_addr_i == rj)) ? wb_fwd_data_i :
                  rf_data_a_i;

    assign src2_reg = (ex_fwd_en_i && (ex_fwd_addr_i == rk)) ? ex_fwd_data_i :
                      (wb_fwd_en_i && (wb_fwd_addr_i == rk)) ? wb_fwd_data_i :
                      rf_data_b_i;

    assign payload_o.pc             = pc_i;
    assign payload_o.inst           = inst_i;
    assign payload_o.alu_op         = alu_op;
    assign payload_o.src1           = src1;
    assign payload_o.src2           = use_imm ? imm : src2_reg;
    assign payload_o.reg_write_en   = !illegal && (rd != '0);
    assign payload_o.reg_write_addr = rd;
    assign payload_o.illegal        = illegal;

endmodule

`default_nettype wire

// File: design/inst_buffer.sv
`default_nettype none

module inst_buffer (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               inst_valid_i,
    input  backend_pkg::word_t inst_i,
    input  backend_pkg::word_t pc_i,
    output logic               inst_ready_o,
    output logic               head_valid_o,
    output backend_pkg::word_t head_inst_o,
    output backend_pkg::word_t head_pc_o,
    input  logic               head_ready_i
);
    import backend_pkg::*;

    word_t                        inst_mem [INST_BUFFER_DEPTH];
    word_t                        pc_mem   [INST_BUFFER_DEPTH];
    logic [INST_BUFFER_PTR_W-1:0] wr_ptr_q;
    logic [INST_BUFFER_PTR_W-1:0] rd_ptr_q;
    logic [INST_BUFFER_CNT_W-1:0] count_q;
    logic                         push;
    logic                         pop;

    assign head_valid_o = (count_q != '0);
    // full buffer still takes a word when the head leaves on the same edge
    assign inst_ready_o = (count_q != INST_BUFFER_CNT_W'(INST_BUFFER_DEPTH)) || head_ready_i;

    assign push = inst_valid_i && inst_ready_o;
    assign pop  = head_valid_o && head_ready_i;

    assign head_inst_o = inst_mem[rd_ptr_q];
    assign head_pc_o   = pc_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[wr_ptr_q] <= inst_i;
            pc_mem[wr_ptr_q]   <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == INST_BUFFER_PTR_W'(INST_BUFFER_DEPTH - 1)) ?
                            '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == INST_BUFFER_PTR_W'(INST_BUFFER_DEPTH - 1)) ?
                            '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_payload_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_payload_o
);

    logic     full_q;
    payload_t data_q;

    // refill on the same edge the entry leaves
    assign in_ready_o = !full_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_payload_i;
        end
    end

    assign out_valid_o   = full_q;
    assign out_payload_o = data_q;

endmodule

`default_nettype wire

// File: design/regfile.sv
`default_nettype none

module regfile (
    input  logic                   clk,
    input  logic                   reset_i,
    input  backend_pkg::reg_addr_t read_addr_a_i,
    input  backend_pkg::reg_addr_t read_addr_b_i,
    output backend_pkg::word_t     read_data_a_o,
    output backend_pkg::word_t     read_data_b_o,
    input  logic                   write_en_i,
    input  backend_pkg::reg_addr_t write_addr_i,
    input  backend_pkg::word_t     write_data_i
);
    import backend_pkg::*;

    word_t regs [NUM_REGS];

    // r0 is never written, so it reads back as zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en_i && (write_addr_i != '0)) begin
            regs[write_addr_i] <= write_data_i;
        end
    end

    assign read_data_a_o = regs[read_addr_a_i];
    assign read_data_b_o = regs[read_addr_b_i];

endmodule

`default_nettype wire

// File: tb/backend_ref_model.svh
`ifndef BACKEND_REF_MODEL_SVH
`define BACKEND_REF_MODEL_SVH

// one expected retirement, kept in acceptance order
typedef struct {
    word_t      pc;
    word_t      inst;
    logic [3:0] wen;
    reg_addr_t  wnum;
    word_t      wdata;
} exp_commit_t;

word_t       arch_regs [NUM_REGS];
exp_commit_t expected_q [$];

function automatic void model_reset();
    for (int i = 0; i < NUM_REGS; i++) begin
        arch_regs[i] = '0;
    end
    expected_q.delete();
endfunction

// executes one accepted instruction on the architectural state
function automatic void model_accept(word_t pc, word_t inst);
    exp_commit_t e;
    reg_addr_t   rd;
    word_t       a;
    word_t       b;
    word_t       res;
    logic        legal;
    rd    = inst[4:0];
    a     = arch_regs[inst[9:5]];
    b     = arch_regs[inst[14:10]];
    res   = '0;
    legal = 1'b1;
    if (inst[31:15] == OP_ADD_W)
        res = a + b;
    else if (inst[31:15] == OP_SUB_W)
        res = a - b;
    else if (inst[31:15] == OP_AND)
        res = a & b;
    else if (inst[31:15] == OP_OR)
        res = a | b;
    else if (inst[31:15] == OP_XOR)
        res = a ^ b;
    else if (inst[31:15] == OP_SLL_W)
        res = a << b[4:0];
    else if (inst[31:15] == OP_SRL_W)
        res = a >> b[4:0];
    else if (inst[31:22] == OP_ADDI_W)
        res = a + {{20{inst[21]}}, inst[21:10]};
    else if (inst[31:25] == OP_LU12I_W)
        res = {inst[24:5], 12'h000};
    else
        legal = 1'b0;
    e.pc    = pc;
    e.inst  = inst;
    e.wen   = (legal && rd != '0) ? 4'hf : 4'h0;
    e.wnum  = rd;
    e.wdata = res;
    if (e.wen != 4'h0) begin
        arch_regs[rd] = res;
    end
    expected_q.push_back(e);
endfunction

`endif

// File: tb/tb_backend.sv
`default_nettype none

module tb_backend;
    import backend_pkg::*;

    `include "backend_ref_model.svh"

    localparam int TIMEOUT_CYCLES = 200;

    logic        clk;
    logic        reset_i;
    logic        inst_valid_i;
    word_t       inst_i;
    word_t       pc_i;
    logic        inst_ready_o;
    logic        commit_valid_o;
    logic        commit_ready_i;
    word_t       debug_wb_pc_o;
    word_t       debug_wb_inst_o;
    logic [3:0]  debug_wb_rf_wen_o;
    reg_addr_t   debug_wb_rf_wnum_o;
    word_t       debug_wb_rf_wdata_o;
    logic [63:0] retired_count_o;

    int          errors;
    int          commit_count;
    word_t       next_pc;
    logic        hold_commit;
    logic        force_ready;

    backend UUT (
        .clk,
        .reset_i,
        .inst_valid_i,
        .inst_i,
        .pc_i,
        .inst_ready_o,
        .commit_valid_o,
        .commit_ready_i,
        .debug_wb_pc_o,
        .debug_wb_inst_o,
        .debug_wb_rf_wen_o,
        .debug_wb_rf_wnum_o,
        .debug_wb_rf_wdata_o,
        .retired_count_o
    );

    always #10 clk = ~clk;

    // mode flags are picked up at the edge, the new ready goes out 2 units later
    always @(posedge clk) begin
        logic ready_next;
        if (hold_commit)
            ready_next = 1'b0;
        else if (force_ready)
            ready_next = 1'b1;
        else
            ready_next = ($urandom_range(0, 99) < 70);
        #2;
        commit_ready_i = ready_next;
    end

    function automatic word_t enc_3r(logic [16:0] op, reg_addr_t rd, reg_addr_t rj,
                                     reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t enc_addi(reg_addr_t rd, reg_addr_t rj, logic [11:0] si12);
        return {OP_ADDI_W, si12, rj, rd};
    endfunction

    function automatic word_t enc_lu12i(reg_addr_t rd, logic [19:0] si20);
        return {OP_LU12I_W, si20, rd};
    endfunction

    // small register range keeps dependencies dense
    function automatic word_t random_inst();
        int        kind;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        kind = $urandom_range(0, 99);
        rd   = 5'($urandom_range(0, 7));
        rj   = 5'($urandom_range(0, 7));
        rk   = 5'($urandom_range(0, 7));
        if (kind < 5)
            return $urandom();
        case ((kind - 5) % 9)
            0: return enc_3r(OP_ADD_W, rd, rj, rk);
            1: return enc_3r(OP_SUB_W, rd, rj, rk);
            2: return enc_3r(OP_AND, rd, rj, rk);
            3: return enc_3r(OP_OR, rd, rj, rk);
            4: return enc_3r(OP_XOR, rd, rj, rk);
            5: return enc_3r(OP_SLL_W, rd, rj, rk);
            6: return enc_3r(OP_SRL_W, rd, rj, rk);
            7: return enc_addi(rd, rj, 12'($urandom()));
            default: return enc_lu12i(rd, 20'($urandom()));
        endcase
    endfunction

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("%0d commits checked, %0d errors", commit_count, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    // outputs compared on the falling edge
    always @(negedge clk) begin
        exp_commit_t e;
        if (!reset_i) begin
            if (retired_count_o !== 64'(commit_count)) begin
                errors++;
                $display("Fail at %0t: retired_count_o expected %0d, got %0d",
                         $time, commit_count, retired_count_o);
            end
            if (commit_valid_o && commit_ready_i) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("commit at %0t with no instruction outstanding", $time);
                end else begin
                    e = expected_q.pop_front();
                    check_word("debug_wb_pc_o", e.pc, debug_wb_pc_o);
                    check_word("debug_wb_inst_o", e.inst, debug_wb_inst_o);
                    check_word("debug_wb_rf_wen_o", 32'(e.wen), 32'(debug_wb_rf_wen_o));
                    if (e.wen != 4'h0) begin
                        check_word("debug_wb_rf_wnum_o", 32'(e.wnum), 32'(debug_wb_rf_wnum_o));
                        check_word("debug_wb_rf_wdata_o", e.wdata, debug_wb_rf_wdata_o);
                    end
                end
                commit_count++;
            end
            if (inst_valid_i && inst_ready_o)
                model_accept(pc_i, inst_i);
        end
    end

    task automatic wait_accept();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!inst_ready_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!inst_ready_o) begin
            errors++;
            $display("timeout at %0t, inst_ready_o stayed low", $time);
            finish_run();
        end else begin
            @(posedge clk);
            #2;
            inst_valid_i = 1'b0;
            next_pc      = next_pc + 4;
        end
    endtask

    task automatic send_inst(word_t inst);
        inst_valid_i = 1'b1;
        inst_i       = inst;
        pc_i         = next_pc;
        wait_accept();
    endtask

    // dependency distances 1 to 3 at full rate plus r0 and illegal words
    task automatic run_dependency_chain();
        force_ready = 1'b1;
        send_inst(enc_lu12i(5'd1, 20'h12345));
        send_inst(enc_addi(5'd1, 5'd1, 12'hfff));
        send_inst(enc_3r(OP_ADD_W, 5'd2, 5'd1, 5'd1));
        send_inst(enc_3r(OP_SUB_W, 5'd3, 5'd2, 5'd1));
        send_inst(enc_3r(OP_XOR, 5'd4, 5'd1, 5'd3));
        send_inst(enc_addi(5'd5, 5'd0, 12'h023));
        send_inst(enc_3r(OP_SLL_W, 5'd6, 5'd4, 5'd5));
        send_inst(enc_3r(OP_SRL_W, 5'd7, 5'd2, 5'd5));
        send_inst(enc_addi(5'd0, 5'd4, 12'h7ff));
        send_inst(enc_3r(OP_OR, 5'd1, 5'd0, 5'd7));
        send_inst(32'hffff_ffff);
        send_inst(enc_3r(OP_AND, 5'd2, 5'd1, 5'd7));
        force_ready = 1'b0;
    endtask

    task automatic run_random(int count);
        for (int i = 0; i < count; i++) begin
            if ($urandom_range(0, 99) < 20) begin
                @(posedge clk);
                #2;
            end
            send_inst(random_inst());
        end
    endtask

    task automatic check_backpressure();
        int   sent;
        logic stalled;
        sent        = 0;
        stalled     = 1'b0;
        hold_commit = 1'b1;
        while (!stalled && sent < 20) begin
            inst_valid_i = 1'b1;
            inst_i       = random_inst();
            pc_i         = next_pc;
            @(negedge clk);
            if (inst_ready_o) begin
                @(posedge clk);
                #2;
                next_pc = next_pc + 4;
                sent++;
            end else begin
                stalled = 1'b1;
            end
        end
        if (!stalled) begin
            errors++;
            $display("inst_ready_o never fell while commit_ready_i was held low");
        end else if (commit_valid_o !== 1'b1) begin
            errors++;
            $display("Fail at %0t: commit_valid_o expected 1, got %b", $time, commit_valid_o);
        end
        hold_commit = 1'b0;
        wait_accept();
    endtask

    task automatic drain();
        int waited;
        waited      = 0;
        force_ready = 1'b1;
        while (expected_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("timeout, %0d instructions never retired", expected_q.size());
        end
        @(negedge clk);
        if (commit_valid_o !== 1'b0) begin
            errors++;
            $display("Fail at %0t: commit_valid_o expected 0, got %b", $time, commit_valid_o);
        end
        if (retired_count_o !== 64'(commit_count)) begin
            errors++;
            $display("Fail at %0t: retired_count_o expected %0d, got %0d",
                     $time, commit_count, retired_count_o);
        end
    endtask

    initial begin
        void'($urandom(93537));
        clk            = 1'b0;
        reset_i        = 1'b1;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        pc_i           = '0;
        commit_ready_i = 1'b0;
        errors         = 0;
        commit_count   = 0;
        next_pc        = 32'h1c00_0000;
        hold_commit    = 1'b0;
        force_ready    = 1'b0;
        model_reset();
        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;
        @(negedge clk);
        if (commit_valid_o !== 1'b0) begin
            errors++;
            $display("Fail at %0t: commit_valid_o expected 0, got %b", $time, commit_valid_o);
        end
        if (inst_ready_o !== 1'b1) begin
            errors++;
            $display("Fail at %0t: inst_ready_o expected 1, got %b", $time, inst_ready_o);
        end
        @(posedge clk);
        #2;
        run_dependency_chain();
        run_random(300);
        check_backpressure();
        run_random(200);
        drain();
        finish_run();
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
design/backend_pkg.sv
design/inst_buffer.sv
design/regfile.sv
design/decoder.sv
design/pipe_stage.sv
design/alu.sv
design/commit_port.sv
design/backend.sv
tb/tb_backend.sv
